// File: all.f
+incdir+include
verilog/pdp_pkg.sv
verilog/pdp_nan.sv
verilog/pdp_pool_calc.sv
verilog/pdp_wdma_out.sv
verilog/pdp_core.sv
tb/pdp_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the pdp_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module pdp_core_tb \
  -o pdp_core_sim || exit 1
./obj_dir/pdp_core_sim > sim.log 2>&1
cat sim.log
grep -qx "No errors" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: include/pdp_tb_vectors.svh
// pdp testbench table: per-test configuration, input beat ranges, input beats
`ifndef PDP_TB_VECTORS_SVH
`define PDP_TB_VECTORS_SVH

// columns: name | flying_mode | nan_to_zero | pool_op (0 max, 1 min) | kernel_width
//          | random write-side back-pressure | first beat | beat count
// expected outputs and counts come from the model in the testbench
localparam int n_tests = 4;
localparam int n_beats = 20;

string      tab_name  [n_tests] = '{"max_flush", "min_nan_pass", "max_kw0", "max_backpressure"};
bit         tab_fm    [n_tests] = '{1'b1, 1'b1, 1'b1, 1'b1};
bit         tab_n2z   [n_tests] = '{1'b1, 1'b0, 1'b0, 1'b0};
bit         tab_op    [n_tests] = '{1'b0, 1'b1, 1'b0, 1'b0};
logic [2:0] tab_kw    [n_tests] = '{3'd2, 3'd3, 3'd0, 3'd4};
bit         tab_bp    [n_tests] = '{1'b0, 1'b0, 1'b0, 1'b1};
int         tab_first [n_tests] = '{0, 5, 11, 14};
int         tab_num   [n_tests] = '{5, 6, 3, 6};

// beat: info (14 bits), lane 3 .. lane 0
// info 14'h2200 marks layer end, 14'h0200 line end
logic [77:0] beat_tab [n_beats] = '{
  // max_flush, line end mid-layer
  {14'h0001, 64'h7e00_3c00_c000_4000},
  {14'h0002, 64'h3800_7c00_bc00_fe00},
  {14'h0203, 64'h4200_fc00_7e01_0000},
  {14'h0004, 64'hbc00_4000_3c00_3800},
  {14'h2205, 64'hc000_7e00_4200_fc00},
  // min_nan_pass
  {14'h0000, 64'h3c00_7e00_fc00_4000},
  {14'h0001, 64'hfe00_4200_3800_7c00},
  {14'h0002, 64'h4000_bc00_c000_3c00},
  {14'h0003, 64'h7c00_3800_7e00_c000},
  {14'h0804, 64'h0000_fc00_3c00_bc00},
  {14'h2205, 64'h3800_4000_fe00_4200},
  // max_kw0
  {14'h0000, 64'h7e00_3c00_4000_c000},
  {14'h0401, 64'h3800_fc00_7c00_0000},
  {14'h2202, 64'hbc00_4200_fe00_3c00},
  // max_backpressure
  {14'h0000, 64'h3c00_4000_7e00_fc00},
  {14'h0201, 64'hc000_3800_7c00_4200},
  {14'h0002, 64'h7e00_bc00_3c00_4000},
  {14'h1003, 64'h4200_7c00_c000_3800},
  {14'h0004, 64'hfc00_fe00_4000_bc00},
  {14'h2205, 64'h3800_4200_0000_7e00}
};

`endif

// File: tb/pdp_core_tb.sv
// testbench for the pdp pooling slice with clock, reset, lfsr back-pressure, table loop, model
`default_nettype none

module pdp_core_tb;
  import pdp_pkg::*;
  `include "pdp_tb_vectors.svh"

  localparam int wait_limit = 300;

  logic         nvdla_core_clk;
  logic         nvdla_core_rstn;
  logic         reg2dp_op_en;
  logic         reg2dp_flying_mode;
  logic         reg2dp_nan_to_zero;
  pdp_pool_op_e reg2dp_pool_op;
  logic [2:0]   reg2dp_kernel_width;
  logic [31:0]  dp2reg_nan_input_num;
  logic [31:0]  dp2reg_inf_input_num;
  logic         dp2reg_done;
  logic         rdma2dp_valid;
  pdp_beat_t    rdma2dp_pd;
  logic         rdma2dp_ready;
  pdp_beat_t    dp2wdma_pd;
  logic         dp2wdma_valid;
  logic         dp2wdma_ready;

  int           errors;
  int           err_before;
  logic [31:0]  lfsr;
  bit           use_bp;
  pdp_beat_t    exp_q[$];
  pdp_beat_t    got_q[$];
  int           exp_nan;
  int           exp_inf;

  pdp_core dut_i (
    .nvdla_core_clk       (nvdla_core_clk),
    .nvdla_core_rstn      (nvdla_core_rstn),
    .reg2dp_op_en         (reg2dp_op_en),
    .reg2dp_flying_mode   (reg2dp_flying_mode),
    .reg2dp_nan_to_zero   (reg2dp_nan_to_zero),
    .reg2dp_pool_op       (reg2dp_pool_op),
    .reg2dp_kernel_width  (reg2dp_kernel_width),
    .dp2reg_nan_input_num (dp2reg_nan_input_num),
    .dp2reg_inf_input_num (dp2reg_inf_input_num),
    .dp2reg_done          (dp2reg_done),
    .rdma2dp_valid        (rdma2dp_valid),
    .rdma2dp_pd           (rdma2dp_pd),
    .rdma2dp_ready        (rdma2dp_ready),
    .dp2wdma_pd           (dp2wdma_pd),
    .dp2wdma_valid        (dp2wdma_valid),
    .dp2wdma_ready        (dp2wdma_ready)
  );

  always #5 nvdla_core_clk = ~nvdla_core_clk;

  ////////////////////
  // helpers
  ////////////////////

  // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
  task automatic lfsr_bit(output logic b);
    b = lfsr[0];
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
  endtask

  task automatic compare_val(input string name, input logic [77:0] expv, input logic [77:0] actv);
    if (expv !== actv) begin
      $display("MISMATCH %s expected %h actual %h", name, expv, actv);
      errors++;
    end
  endtask

  // model flushes, counts raw nan/inf lanes and pools each window by order key
  task automatic build_expect(input int t);
    logic [3:0][15:0] acc;
    logic [15:0]      v;
    pdp_beat_t        b;
    pdp_beat_t        o;
    int               cnt;
    int               k;
    exp_q.delete();
    exp_nan = 0;
    exp_inf = 0;
    cnt     = 0;
    k       = (tab_kw[t] == 3'd0) ? 1 : int'(tab_kw[t]);
    for (int i = 0; i < tab_num[t]; i++) begin
      b = beat_tab[tab_first[t] + i];
      for (int l = 0; l < 4; l++) begin
        v = b.data[l];
        if (fp16_is_nan(v)) begin
          exp_nan++;
          if (tab_n2z[t]) v = 16'h0000;
        end
        if (fp16_is_inf(v)) exp_inf++;
        if (cnt == 0) acc[l] = v;
        else if (!tab_op[t] && fp16_order_key(v) > fp16_order_key(acc[l])) acc[l] = v;
        else if (tab_op[t] && fp16_order_key(v) < fp16_order_key(acc[l])) acc[l] = v;
      end
      cnt++;
      // window closes on width or line end
      if (cnt == k || b.info.line_end) begin
        o.info = b.info;
        o.data = acc;
        exp_q.push_back(o);
        cnt = 0;
      end
    end
  endtask

  // hold a beat on the input while the gate should stay shut
  task automatic check_gate_closed(input string name);
    @(negedge nvdla_core_clk);
    rdma2dp_valid = 1'b1;
    rdma2dp_pd    = beat_tab[0];
    for (int i = 0; i < 8; i++) begin
      @(posedge nvdla_core_clk);
      if (rdma2dp_ready) begin
        $display("%s: input ready went high while the gate was closed", name);
        errors++;
      end
      if (dp2wdma_valid) begin
        $display("%s: an output appeared while the gate was closed", name);
        errors++;
      end
    end
    @(negedge nvdla_core_clk);
    rdma2dp_valid = 1'b0;
  endtask

  ////////////////////
  // layer driver / monitor
  ////////////////////

  task automatic drive_layer(input int t);
    int waited;
    for (int i = 0; i < tab_num[t]; i++) begin
      @(negedge nvdla_core_clk);
      rdma2dp_valid = 1'b1;
      rdma2dp_pd    = beat_tab[tab_first[t] + i];
      waited        = 0;
      @(posedge nvdla_core_clk);
      while (!rdma2dp_ready && waited < wait_limit) begin
        waited++;
        @(posedge nvdla_core_clk);
      end
      if (waited >= wait_limit) begin
        $display("%s: timed out waiting for input beat %0d to be accepted", tab_name[t], i);
        errors++;
        break;
      end
    end
    @(negedge nvdla_core_clk);
    rdma2dp_valid = 1'b0;
    // gate shut after layer end
    for (int i = 0; i < 3; i++) begin
      if (rdma2dp_ready) begin
        $display("%s: input ready still high after the layer end beat", tab_name[t]);
        errors++;
      end
      @(negedge nvdla_core_clk);
    end
  endtask

  task automatic collect_layer(input int t);
    int   waited;
    logic b;
    logic done_seen;
    logic end_xfer;
    got_q.delete();
    done_seen = 1'b0;
    end_xfer  = 1'b0;
    waited    = 0;
    while (!(done_seen && got_q.size() >= exp_q.size())) begin
      @(negedge nvdla_core_clk);
      lfsr_bit(b);
      dp2wdma_ready = use_bp ? b : 1'b1;
      @(posedge nvdla_core_clk);
      // done pulses only in the cycle after a layer-end beat leaves
      compare_val({tab_name[t], " done"}, 78'(end_xfer), 78'(dp2reg_done));
      end_xfer = dp2wdma_valid && dp2wdma_ready && dp2wdma_pd.info.cube_end &&
                 dp2wdma_pd.info.line_end;
      if (dp2wdma_valid && dp2wdma_ready) got_q.push_back(dp2wdma_pd);
      if (dp2reg_done) done_seen = 1'b1;
      waited++;
      if (waited > wait_limit) begin
        $display("%s: timed out waiting for outputs and the done pulse", tab_name[t]);
        errors++;
        break;
      end
    end
    // counts load one cycle after done
    @(negedge nvdla_core_clk);
    dp2wdma_ready = 1'b1;
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    nvdla_core_clk      = 1'b0;
    nvdla_core_rstn     = 1'b0;
    reg2dp_op_en        = 1'b0;
    reg2dp_flying_mode  = 1'b1;
    reg2dp_nan_to_zero  = 1'b0;
    reg2dp_pool_op      = pool_max;
    reg2dp_kernel_width = 3'd1;
    rdma2dp_valid       = 1'b0;
    rdma2dp_pd          = '0;
    dp2wdma_ready       = 1'b1;
    lfsr                = 32'hd092_f154;
    errors              = 0;
    repeat (5) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;

    err_before = errors;
    check_gate_closed("gate_before_op_en");
    $display("test gate_before_op_en: %0d errors", errors - err_before);
    // op_en edge in on-fly mode keeps rdma side shut
    err_before = errors;
    @(negedge nvdla_core_clk);
    reg2dp_flying_mode = 1'b0;
    reg2dp_op_en       = 1'b1;
    @(negedge nvdla_core_clk);
    reg2dp_op_en = 1'b0;
    check_gate_closed("gate_onfly_op_en");
    $display("test gate_onfly_op_en: %0d errors", errors - err_before);

    for (int t = 0; t < n_tests; t++) begin
      err_before = errors;
      build_expect(t);
      use_bp = tab_bp[t];
      @(negedge nvdla_core_clk);
      reg2dp_flying_mode  = tab_fm[t];
      reg2dp_nan_to_zero  = tab_n2z[t];
      reg2dp_pool_op      = pdp_pool_op_e'(tab_op[t]);
      reg2dp_kernel_width = tab_kw[t];
      reg2dp_op_en        = 1'b1;
      @(negedge nvdla_core_clk);
      reg2dp_op_en = 1'b0;
      fork
        drive_layer(t);
        collect_layer(t);
      join
      if (got_q.size() != exp_q.size()) begin
        $display("%s: expected %0d output beats but saw %0d", tab_name[t], exp_q.size(),
                 got_q.size());
        errors++;
      end
      for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
        compare_val($sformatf("%s out%0d", tab_name[t], i), exp_q[i], got_q[i]);
      end
      compare_val({tab_name[t], " nan_count"}, 78'(exp_nan), 78'(dp2reg_nan_input_num));
      compare_val({tab_name[t], " inf_count"}, 78'(exp_inf), 78'(dp2reg_inf_input_num));
      $display("test %s: %0d outputs, %0d errors", tab_name[t], got_q.size(),
               errors - err_before);
    end

    $display("summary: %0d tests, %0d errors", n_tests + 2, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/pdp_core.sv
// pdp_core: pdp pooling slice top, decode / pool / write-out stages
`default_nettype none

module pdp_core (
  input  wire                           nvdla_core_clk,
  input  wire                           nvdla_core_rstn,
  // register side
  input  wire                           reg2dp_op_en,
  input  wire                           reg2dp_flying_mode,
  input  wire                           reg2dp_nan_to_zero,
  input  wire pdp_pkg::pdp_pool_op_e    reg2dp_pool_op,
  input  wire [2:0]                     reg2dp_kernel_width,
  output logic [pdp_pkg::pdp_cnt_w-1:0] dp2reg_nan_input_num,
  output logic [pdp_pkg::pdp_cnt_w-1:0] dp2reg_inf_input_num,
  output logic                          dp2reg_done,
  // read dma in
  input  wire                           rdma2dp_valid,
  input  wire pdp_pkg::pdp_beat_t       rdma2dp_pd,
  output logic                          rdma2dp_ready,
  // write dma out
  output pdp_pkg::pdp_beat_t            dp2wdma_pd,
  output logic                          dp2wdma_valid,
  input  wire                           dp2wdma_ready
);
  import pdp_pkg::*;

  // decode to pool
  pdp_beat_t nan_preproc_pd;
  logic      nan_preproc_pvld;
  logic      nan_preproc_prdy;
  // pool to write-out
  pdp_beat_t pool_pd;
  logic      pool_pvld;
  logic      pool_prdy;

  ////////////////////
  // stages
  ////////////////////

  // gate, nan flush, counters
  pdp_nan u_nan (
    .nvdla_core_clk       (nvdla_core_clk),
    .nvdla_core_rstn      (nvdla_core_rstn),
    .dp2reg_done          (dp2reg_done),
    .reg2dp_op_en         (reg2dp_op_en),
    .reg2dp_flying_mode   (reg2dp_flying_mode),
    .reg2dp_nan_to_zero   (reg2dp_nan_to_zero),
    .rdma2dp_valid        (rdma2dp_valid),
    .rdma2dp_pd           (rdma2dp_pd),
    .rdma2dp_ready        (rdma2dp_ready),
    .nan_preproc_pd       (nan_preproc_pd),
    .nan_preproc_pvld     (nan_preproc_pvld),
    .nan_preproc_prdy     (nan_preproc_prdy),
    .dp2reg_nan_input_num (dp2reg_nan_input_num),
    .dp2reg_inf_input_num (dp2reg_inf_input_num)
  );

  // max/min windows
  pdp_pool_calc u_pool_calc (
    .nvdla_core_clk      (nvdla_core_clk),
    .nvdla_core_rstn     (nvdla_core_rstn),
    .nan_preproc_pd      (nan_preproc_pd),
    .nan_preproc_pvld    (nan_preproc_pvld),
    .nan_preproc_prdy    (nan_preproc_prdy),
    .reg2dp_pool_op      (reg2dp_pool_op),
    .reg2dp_kernel_width (reg2dp_kernel_width),
    .pool_pd             (pool_pd),
    .pool_pvld           (pool_pvld),
    .pool_prdy           (pool_prdy)
  );

  // output reg + done pulse, done loops back to counters
  pdp_wdma_out u_wdma_out (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .pool_pd         (pool_pd),
    .pool_pvld       (pool_pvld),
    .pool_prdy       (pool_prdy),
    .dp2wdma_pd      (dp2wdma_pd),
    .dp2wdma_valid   (dp2wdma_valid),
    .dp2wdma_ready   (dp2wdma_ready),
    .dp2reg_done     (dp2reg_done)
  );

endmodule

`default_nettype wire

// File: verilog/pdp_nan.sv
// pdp_nan: op_en gate, nan/inf classification, nan flush, per-layer nan/inf counters
`default_nettype none

module pdp_nan (
  input  wire                             nvdla_core_clk,
  input  wire                             nvdla_core_rstn,
  input  wire                             dp2reg_done,
  input  wire                             reg2dp_op_en,
  input  wire                             reg2dp_flying_mode,
  input  wire                             reg2dp_nan_to_zero,
  input  wire                             rdma2dp_valid,
  input  wire pdp_pkg::pdp_beat_t         rdma2dp_pd,
  output logic                            rdma2dp_ready,
  output pdp_pkg::pdp_beat_t              nan_preproc_pd,
  output logic                            nan_preproc_pvld,
  input  wire                             nan_preproc_prdy,
  output logic [pdp_pkg::pdp_cnt_w-1:0]   dp2reg_nan_input_num,
  output logic [pdp_pkg::pdp_cnt_w-1:0]   dp2reg_inf_input_num
);
  import pdp_pkg::*;

  logic                                    op_en_d1;
  logic                                    op_en_load;
  logic                                    onfly_en;
  logic                                    waiting_for_op_en;
  logic                                    load_din;
  logic                                    layer_end;
  logic [pdp_throughput-1:0]               dat_is_nan;
  logic [pdp_throughput-1:0]               dat_is_inf;
  logic [2:0]                              nan_num;
  logic [2:0]                              inf_num;
  logic [pdp_throughput-1:0][pdp_bwpe-1:0] din_data;
  logic [pdp_cnt_w-1:0]                    nan_in_count;
  logic [pdp_cnt_w-1:0]                    inf_in_count;
  logic [pdp_cnt_w-1:0]                    nan_cnt_nxt;
  logic [pdp_cnt_w-1:0]                    inf_cnt_nxt;
  logic [1:0][pdp_cnt_w-1:0]               nan_bank;
  logic [1:0][pdp_cnt_w-1:0]               inf_bank;
  logic                                    layer_flag;
  logic                                    wdma_layer_flag;

  ////////////////////
  // input handshake
  ////////////////////

  // open when output reg empty or draining, and gate not waiting
  assign rdma2dp_ready = (~nan_preproc_pvld | nan_preproc_prdy) & ~waiting_for_op_en;
  assign load_din      = rdma2dp_valid & rdma2dp_ready;
  // flying_mode 0 is on-fly
  assign onfly_en      = ~reg2dp_flying_mode;

  ////////////////////
  // op_en gate
  ////////////////////

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_d1 <= 1'b0;
    end else begin
      op_en_d1 <= reg2dp_op_en;
    end
  end

  // rising edge of op_en
  assign op_en_load = reg2dp_op_en & ~op_en_d1;
  // last beat of the layer taken this cycle
  assign layer_end  = load_din & rdma2dp_pd.info.cube_end & rdma2dp_pd.info.line_end;

  // closed out of reset
  // layer end wins over a coincident op_en edge
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      waiting_for_op_en <= 1'b1;
    end else if (layer_end & ~onfly_en) begin
      waiting_for_op_en <= 1'b1;
    end else if (op_en_load) begin
      // on-fly keeps rdma side shut
      waiting_for_op_en <= onfly_en;
    end
  end

  ////////////////////
  // classify + flush
  ////////////////////

  always_comb begin
    nan_num = 3'd0;
    inf_num = 3'd0;
    for (int i = 0; i < pdp_throughput; i++) begin
      dat_is_nan[i] = fp16_is_nan(rdma2dp_pd.data[i]);
      dat_is_inf[i] = fp16_is_inf(rdma2dp_pd.data[i]);
      nan_num       = nan_num + {2'b00, dat_is_nan[i]};
      inf_num       = inf_num + {2'b00, dat_is_inf[i]};
      // nan lanes forced to +0 when flush enabled
      din_data[i]   = (dat_is_nan[i] & reg2dp_nan_to_zero) ? '0 : rdma2dp_pd.data[i];
    end
  end

  // output payload
  always_ff @(posedge nvdla_core_clk) begin
    if (load_din) begin
      nan_preproc_pd.info <= rdma2dp_pd.info;
      nan_preproc_pd.data <= din_data;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      nan_preproc_pvld <= 1'b0;
    end else if (load_din) begin
      nan_preproc_pvld <= 1'b1;
    end else if (nan_preproc_prdy) begin
      nan_preproc_pvld <= 1'b0;
    end
  end

  ////////////////////
  // nan / inf counts
  ////////////////////

  assign nan_cnt_nxt = nan_in_count + pdp_cnt_w'(nan_num);
  assign inf_cnt_nxt = inf_in_count + pdp_cnt_w'(inf_num);

  // running count, dumped into alternating bank at layer end
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      nan_in_count <= '0;
      inf_in_count <= '0;
      nan_bank     <= '0;
      inf_bank     <= '0;
      layer_flag   <= 1'b0;
    end else if (layer_end) begin
      nan_bank[layer_flag] <= nan_cnt_nxt;
      inf_bank[layer_flag] <= inf_cnt_nxt;
      layer_flag           <= ~layer_flag;
      nan_in_count         <= '0;
      inf_in_count         <= '0;
    end else if (load_din) begin
      nan_in_count <= nan_cnt_nxt;
      inf_in_count <= inf_cnt_nxt;
    end
  end

  // report side follows done pulses, same ping-pong order
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wdma_layer_flag      <= 1'b0;
      dp2reg_nan_input_num <= '0;
      dp2reg_inf_input_num <= '0;
    end else if (dp2reg_done) begin
      wdma_layer_flag      <= ~wdma_layer_flag;
      dp2reg_nan_input_num <= nan_bank[wdma_layer_flag];
      dp2reg_inf_input_num <= inf_bank[wdma_layer_flag];
    end
  end

  // gate shut the cycle after an off-fly layer end or an on-fly op_en edge
  gate_closes_a : assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    ((layer_end & ~onfly_en) | (op_en_load & onfly_en)) |=> !rdma2dp_ready);

endmodule

`default_nettype wire

// File: verilog/pdp_pkg.sv
// pdp_pkg: beat widths, info and beat structs, pooling opcode enum, fp16 helpers
`default_nettype none

package pdp_pkg;

  ////////////////////
  // beat geometry
  ////////////////////

  // lanes per beat
  localparam int pdp_throughput = 4;
  // bits per element, fp16
  localparam int pdp_bwpe = 16;
  // nan / inf counter width
  localparam int pdp_cnt_w = 32;

  // position info, msb first
  // layer end is cube_end together with line_end
  typedef struct packed {
    logic       cube_end;
    logic       split_end;
    logic       surf_end;
    logic       pos_c;
    logic       line_end;
    logic [8:0] pos_w;
  } pdp_info_t;

  // one beat: info on top, lane 0 in the lowest bits
  typedef struct packed {
    pdp_info_t                               info;
    logic [pdp_throughput-1:0][pdp_bwpe-1:0] data;
  } pdp_beat_t;

  // pooling opcode
  typedef enum logic {
    pool_max = 1'b0,
    pool_min = 1'b1
  } pdp_pool_op_e;

  ////////////////////
  // fp16 helpers
  ////////////////////

  // exponent all ones, mantissa nonzero
  function automatic logic fp16_is_nan(input logic [pdp_bwpe-1:0] x);
    return (&x[14:10]) & (|x[9:0]);
  endfunction

  // exponent all ones, mantissa zero
  function automatic logic fp16_is_inf(input logic [pdp_bwpe-1:0] x);
    return (&x[14:10]) & ~(|x[9:0]);
  endfunction

  // unsigned key for total order compare
  // positives: flip sign bit, negatives: invert everything
  // so +nan sorts above +inf, -nan below -inf
  function automatic logic [pdp_bwpe-1:0] fp16_order_key(input logic [pdp_bwpe-1:0] x);
    if (x[pdp_bwpe-1]) begin
      return ~x;
    end
    return {1'b1, x[pdp_bwpe-2:0]};
  endfunction

endpackage

`default_nettype wire

// File: verilog/pdp_pool_calc.sv
// pdp_pool_calc: per-lane 1-d max/min pooling over a beat window, window FSM
`default_nettype none

module pdp_pool_calc (
  input  wire                        nvdla_core_clk,
  input  wire                        nvdla_core_rstn,
  input  wire pdp_pkg::pdp_beat_t    nan_preproc_pd,
  input  wire                        nan_preproc_pvld,
  output logic                       nan_preproc_prdy,
  input  wire pdp_pkg::pdp_pool_op_e reg2dp_pool_op,
  input  wire [2:0]                  reg2dp_kernel_width,
  output pdp_pkg::pdp_beat_t         pool_pd,
  output logic                       pool_pvld,
  input  wire                        pool_prdy
);
  import pdp_pkg::*;

  typedef enum logic {
    win_idle,
    win_accum
  } win_state_e;

  win_state_e                              win_state;
  logic [2:0]                              beat_cnt;
  logic [2:0]                              last_cnt;
  logic                                    load_din;
  logic                                    win_last;
  logic [pdp_throughput-1:0][pdp_bwpe-1:0] acc_data;
  logic [pdp_throughput-1:0][pdp_bwpe-1:0] cmb_data;

  // keep acc or take new lane, by total-order key
  function automatic logic [pdp_bwpe-1:0] pool_pick(input pdp_pool_op_e op,
                                                    input logic [pdp_bwpe-1:0] acc,
                                                    input logic [pdp_bwpe-1:0] din);
    logic take_din;
    if (op == pool_max) begin
      take_din = fp16_order_key(din) > fp16_order_key(acc);
    end else begin
      take_din = fp16_order_key(din) < fp16_order_key(acc);
    end
    return take_din ? din : acc;
  endfunction

  ////////////////////
  // window control
  ////////////////////

  // stall while a result sits unaccepted
  assign nan_preproc_prdy = ~pool_pvld | pool_prdy;
  assign load_din         = nan_preproc_pvld & nan_preproc_prdy;

  // kernel width 0 behaves as 1
  assign last_cnt = (reg2dp_kernel_width == 3'd0) ? 3'd0 : reg2dp_kernel_width - 3'd1;
  // full window or line end, whichever first
  assign win_last = (beat_cnt >= last_cnt) | nan_preproc_pd.info.line_end;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      win_state <= win_idle;
      beat_cnt  <= 3'd0;
    end else if (load_din) begin
      if (win_last) begin
        win_state <= win_idle;
        beat_cnt  <= 3'd0;
      end else begin
        win_state <= win_accum;
        beat_cnt  <= beat_cnt + 3'd1;
      end
    end
  end

  ////////////////////
  // lane datapath
  ////////////////////

  // first beat of a window loads as is
  always_comb begin
    for (int i = 0; i < pdp_throughput; i++) begin
      if (win_state == win_idle) begin
        cmb_data[i] = nan_preproc_pd.data[i];
      end else begin
        cmb_data[i] = pool_pick(reg2dp_pool_op, acc_data[i], nan_preproc_pd.data[i]);
      end
    end
  end

  // acc for mid-window beats, result reg gets the closing beat
  always_ff @(posedge nvdla_core_clk) begin
    if (load_din) begin
      if (win_last) begin
        pool_pd.info <= nan_preproc_pd.info;
        pool_pd.data <= cmb_data;
      end else begin
        acc_data <= cmb_data;
      end
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pool_pvld <= 1'b0;
    end else if (load_din & win_last) begin
      pool_pvld <= 1'b1;
    end else if (pool_prdy) begin
      pool_pvld <= 1'b0;
    end
  end

  // held result stays put until taken
  pool_hold_a : assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (pool_pvld && !pool_prdy) |=> (pool_pvld && $stable(pool_pd)));

endmodule

`default_nettype wire

// File: verilog/pdp_wdma_out.sv
// pdp_wdma_out: write-side output register, layer-end detect, done pulse
`default_nettype none

module pdp_wdma_out (
  input  wire                     nvdla_core_clk,
  input  wire                     nvdla_core_rstn,
  input  wire pdp_pkg::pdp_beat_t pool_pd,
  input  wire                     pool_pvld,
  output logic                    pool_prdy,
  output pdp_pkg::pdp_beat_t      dp2wdma_pd,
  output logic                    dp2wdma_valid,
  input  wire                     dp2wdma_ready,
  output logic                    dp2reg_done
);

  logic load_pool;
  logic out_xfer;
  logic out_layer_end;

  ////////////////////
  // output register
  ////////////////////

  // take a new result when empty or draining
  assign pool_prdy = ~dp2wdma_valid | dp2wdma_ready;
  assign load_pool = pool_pvld & pool_prdy;

  always_ff @(posedge nvdla_core_clk) begin
    if (load_pool) begin
      dp2wdma_pd <= pool_pd;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      dp2wdma_valid <= 1'b0;
    end else if (load_pool) begin
      dp2wdma_valid <= 1'b1;
    end else if (dp2wdma_ready) begin
      dp2wdma_valid <= 1'b0;
    end
  end

  ////////////////////
  // layer done
  ////////////////////

  assign out_xfer      = dp2wdma_valid & dp2wdma_ready;
  // cube end on a line end closes the layer
  assign out_layer_end = dp2wdma_pd.info.cube_end & dp2wdma_pd.info.line_end;

  // one pulse, cycle after the last beat leaves
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      dp2reg_done <= 1'b0;
    end else begin
      dp2reg_done <= out_xfer & out_layer_end;
    end
  end

  // upstream gate keeps layer ends apart
  done_single_a : assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    dp2reg_done |=> !dp2reg_done);

endmodule

`default_nettype wire
